/* rtl/frame_sync_defines.svh */
`ifndef FRAME_SYNC_DEFINES_SVH
`define FRAME_SYNC_DEFINES_SVH

// ssb timing scaled down for simulation
`define FS_SSB_PERIOD 200
`define FS_SSB_WINDOW 8
`define FS_MAX_MISSED 3

// axi-lite byte address width
`define FS_ADDR_WIDTH 11

// register word indices
`define FS_REG_VERSION     9'd0
`define FS_REG_ID          9'd1
`define FS_REG_MAGIC       9'd3
`define FS_REG_PATTERN     9'd4
`define FS_REG_STATE       9'd5
`define FS_REG_MISMATCH    9'd9
`define FS_REG_MISSED      9'd10
`define FS_REG_IBAR        9'd11
`define FS_REG_PERIOD      9'd12
`define FS_REG_DISCONNECTS 9'd13

// identification words
// the magic word reads "FS~~"
`define FS_CORE_VERSION 32'h00010061
`define FS_MAGIC        32'h46537E7E
`define FS_PATTERN      32'h69696969

`endif

/* rtl/frame_sync_pkg.sv */
package frame_sync_pkg;

    // sync state of the ssb tracker
    // encoding 3 is never used
    typedef enum logic [1:0] {
        FS_SEARCH   = 2'd0,
        FS_DETECTED = 2'd1,
        FS_SYNCED   = 2'd2
    } fs_state_t;

endpackage

/* rtl/ssb_tracker.sv */
`timescale 1ns/1ps
`include "frame_sync_defines.svh"

module ssb_tracker
    import frame_sync_pkg::*;
(
    input  logic               clk_i,
    input  logic               reset_ni,
    input  logic               ssb_strobe_i,
    input  logic        [2:0]  ibar_i,
    output fs_state_t          fs_state_o,
    output logic signed [7:0]  sample_cnt_mismatch_o,
    output logic        [15:0] missed_ssbs_o,
    output logic        [2:0]  ibar_ssb_o,
    output logic        [31:0] clks_btwn_ssbs_o,
    output logic        [31:0] num_disconnects_o
);

    localparam int MISS_W = $clog2(`FS_MAX_MISSED + 1);

    logic        [31:0]     clk_cnt;
    logic        [31:0]     gap;
    logic        [MISS_W-1:0] miss_cnt;
    logic                   in_window;
    logic                   accept;
    logic                   timeout;
    logic signed [32:0]     gap_err;

    // clip the timing error to the signed 8-bit register range
    function automatic logic signed [7:0] sat8(input logic signed [32:0] v);
        logic signed [7:0] r;
        if (v > 33'sd127) begin
            r = 8'sd127;
        end else if (v < -33'sd128) begin
            r = -8'sd128;
        end else begin
            r = v[7:0];
        end
        return r;
    endfunction

    // clocks since the last accepted ssb including the strobe cycle
    assign gap = clk_cnt + 32'd1;

    assign in_window = (gap >= 32'(`FS_SSB_PERIOD - `FS_SSB_WINDOW)) &&
                       (gap <= 32'(`FS_SSB_PERIOD + `FS_SSB_WINDOW));

    // outside of synced any strobe is taken but in synced only inside the window
    assign accept = ssb_strobe_i && ((fs_state_o != FS_SYNCED) || in_window);

    // expected ssb did not arrive by the end of the window
    assign timeout = (fs_state_o == FS_SYNCED) && !accept &&
                     (gap >= 32'(`FS_SSB_PERIOD + `FS_SSB_WINDOW));

    assign gap_err = $signed({1'b0, gap}) - $signed(33'(`FS_SSB_PERIOD));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fs_state_o            <= FS_SEARCH;
            clk_cnt               <= '0;
            miss_cnt              <= '0;
            sample_cnt_mismatch_o <= '0;
            missed_ssbs_o         <= '0;
            ibar_ssb_o            <= '0;
            clks_btwn_ssbs_o      <= '0;
            num_disconnects_o     <= '0;
        end else begin
            clk_cnt <= clk_cnt + 32'd1;

            case (fs_state_o)
                FS_SEARCH: begin
                    if (ssb_strobe_i) begin
                        fs_state_o <= FS_DETECTED;
                    end
                end
                FS_DETECTED: begin
                    if (ssb_strobe_i) begin
                        fs_state_o       <= FS_SYNCED;
                        clks_btwn_ssbs_o <= gap;
                    end
                end
                FS_SYNCED: begin
                    if (accept) begin
                        clks_btwn_ssbs_o      <= gap;
                        sample_cnt_mismatch_o <= sat8(gap_err);
                        miss_cnt              <= '0;
                    end else if (timeout) begin
                        missed_ssbs_o <= missed_ssbs_o + 16'd1;
                        // keeps the next expectation on the nominal grid
                        clk_cnt <= 32'(`FS_SSB_WINDOW);
                        if (miss_cnt == MISS_W'(`FS_MAX_MISSED - 1)) begin
                            fs_state_o        <= FS_SEARCH;
                            num_disconnects_o <= num_disconnects_o + 32'd1;
                            miss_cnt          <= '0;
                        end else begin
                            miss_cnt <= miss_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    fs_state_o <= FS_SEARCH;
                end
            endcase

            // every accepted ssb restarts the count and records its index
            if (accept) begin
                clk_cnt    <= '0;
                ibar_ssb_o <= ibar_i;
            end
        end
    end

    a_state_legal: assert property (@(posedge clk_i) disable iff (!reset_ni)
        fs_state_o inside {FS_SEARCH, FS_DETECTED, FS_SYNCED});

    // a miss is only ever counted against an established sync
    a_miss_only_synced: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $past(reset_ni) && (missed_ssbs_o != $past(missed_ssbs_o))
        |-> ($past(fs_state_o) == FS_SYNCED));

endmodule

/* rtl/frame_sync_regmap.sv */
`timescale 1ns/1ps
`include "frame_sync_defines.svh"

module frame_sync_regmap
    import frame_sync_pkg::*;
#(
    parameter logic [31:0] ID = 32'h0
) (
    input  logic               clk_i,
    input  logic               reset_ni,
    // status from the tracker
    input  fs_state_t          fs_state_i,
    input  logic signed [7:0]  sample_cnt_mismatch_i,
    input  logic        [15:0] missed_ssbs_i,
    input  logic        [2:0]  ibar_ssb_i,
    input  logic        [31:0] clks_btwn_ssbs_i,
    input  logic        [31:0] num_disconnects_i,
    // request side of the bus slave
    input  logic               rreq_i,
    input  logic        [8:0]  raddr_i,
    input  logic               wreq_i,
    // write address and data are not decoded as no field is writable
    input  logic        [8:0]  waddr_i,
    input  logic        [31:0] wdata_i,
    output logic        [31:0] rdata_o,
    output logic               rack_o,
    output logic               wack_o
);

    // acknowledges follow their request by one cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rack_o <= 1'b0;
            wack_o <= 1'b0;
        end else begin
            rack_o <= rreq_i;
            wack_o <= wreq_i;
        end
    end

    // read data is sampled on the request cycle
    always_ff @(posedge clk_i) begin
        if (rreq_i) begin
            case (raddr_i)
                `FS_REG_VERSION: begin
                    rdata_o <= `FS_CORE_VERSION;
                end
                `FS_REG_ID: begin
                    rdata_o <= ID;
                end
                `FS_REG_MAGIC: begin
                    rdata_o <= `FS_MAGIC;
                end
                `FS_REG_PATTERN: begin
                    rdata_o <= `FS_PATTERN;
                end
                `FS_REG_STATE: begin
                    rdata_o <= {30'd0, fs_state_i};
                end
                `FS_REG_MISMATCH: begin
                    // sign extended
                    rdata_o <= {{24{sample_cnt_mismatch_i[7]}}, sample_cnt_mismatch_i};
                end
                `FS_REG_MISSED: begin
                    rdata_o <= {16'd0, missed_ssbs_i};
                end
                `FS_REG_IBAR: begin
                    rdata_o <= {29'd0, ibar_ssb_i};
                end
                `FS_REG_PERIOD: begin
                    rdata_o <= clks_btwn_ssbs_i;
                end
                `FS_REG_DISCONNECTS: begin
                    rdata_o <= num_disconnects_i;
                end
                default: begin
                    rdata_o <= 32'd0;
                end
            endcase
        end
    end

    // each read request is answered next cycle with no new request on top of it
    a_rack_after_rreq: assert property (@(posedge clk_i) disable iff (!reset_ni)
        rreq_i |=> rack_o && !rreq_i);

endmodule

/* rtl/axi_lite_slave.sv */
`timescale 1ns/1ps
`include "frame_sync_defines.svh"

module axi_lite_slave (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    // write address and data
    input  logic [`FS_ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [31:0]               s_axi_wdata_i,
    // byte strobes are accepted but have no effect
    input  logic [3:0]                s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    // write response
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,
    // read address
    input  logic [`FS_ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    // read data
    output logic [31:0]               s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i,
    // register map side
    output logic                      wreq_o,
    output logic [8:0]                waddr_o,
    output logic [31:0]               wdata_o,
    input  logic                      wack_i,
    output logic                      rreq_o,
    output logic [8:0]                raddr_o,
    input  logic [31:0]               rdata_i,
    input  logic                      rack_i
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_ACK  = 2'd2,
        ST_RESP = 2'd3
    } xfer_state_t;

    xfer_state_t w_state;
    xfer_state_t r_state;

    // the map never reports an error
    assign s_axi_bresp_o = 2'b00;
    assign s_axi_rresp_o = 2'b00;

    assign wreq_o = (w_state == ST_REQ);
    assign rreq_o = (r_state == ST_REQ);

    // write path takes address and data together
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            w_state         <= ST_IDLE;
            s_axi_awready_o <= 1'b0;
            s_axi_wready_o  <= 1'b0;
            s_axi_bvalid_o  <= 1'b0;
        end else begin
            case (w_state)
                ST_IDLE: begin
                    s_axi_awready_o <= 1'b0;
                    s_axi_wready_o  <= 1'b0;
                    if (s_axi_awready_o && s_axi_awvalid_i && s_axi_wvalid_i) begin
                        waddr_o <= s_axi_awaddr_i[`FS_ADDR_WIDTH-1:2];
                        wdata_o <= s_axi_wdata_i;
                        w_state <= ST_REQ;
                    end else if (!s_axi_awready_o && s_axi_awvalid_i && s_axi_wvalid_i) begin
                        s_axi_awready_o <= 1'b1;
                        s_axi_wready_o  <= 1'b1;
                    end
                end
                ST_REQ: begin
                    w_state <= ST_ACK;
                end
                ST_ACK: begin
                    if (wack_i) begin
                        s_axi_bvalid_o <= 1'b1;
                        w_state        <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (s_axi_bready_i) begin
                        s_axi_bvalid_o <= 1'b0;
                        w_state        <= ST_IDLE;
                    end
                end
                default: begin
                    w_state <= ST_IDLE;
                end
            endcase
        end
    end

    // read path captures rdata with the acknowledge
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            r_state         <= ST_IDLE;
            s_axi_arready_o <= 1'b0;
            s_axi_rvalid_o  <= 1'b0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    s_axi_arready_o <= 1'b0;
                    if (s_axi_arready_o && s_axi_arvalid_i) begin
                        raddr_o <= s_axi_araddr_i[`FS_ADDR_WIDTH-1:2];
                        r_state <= ST_REQ;
                    end else if (!s_axi_arready_o && s_axi_arvalid_i) begin
                        s_axi_arready_o <= 1'b1;
                    end
                end
                ST_REQ: begin
                    r_state <= ST_ACK;
                end
                ST_ACK: begin
                    if (rack_i) begin
                        s_axi_rdata_o  <= rdata_i;
                        s_axi_rvalid_o <= 1'b1;
                        r_state        <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (s_axi_rready_i) begin
                        s_axi_rvalid_o <= 1'b0;
                        r_state        <= ST_IDLE;
                    end
                end
                default: begin
                    r_state <= ST_IDLE;
                end
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o));

endmodule

/* rtl/frame_sync_top.sv */
`timescale 1ns/1ps
`include "frame_sync_defines.svh"

module frame_sync_top
    import frame_sync_pkg::*;
#(
    parameter logic [31:0] ID = 32'h0
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    // ssb detector
    input  logic                      ssb_strobe_i,
    input  logic [2:0]                ibar_i,
    // axi-lite slave port
    input  logic [`FS_ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [31:0]               s_axi_wdata_i,
    input  logic [3:0]                s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,
    input  logic [`FS_ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output logic [31:0]               s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i
);

    // tracker status
    fs_state_t          fs_state;
    logic signed [7:0]  sample_cnt_mismatch;
    logic        [15:0] missed_ssbs;
    logic        [2:0]  ibar_ssb;
    logic        [31:0] clks_btwn_ssbs;
    logic        [31:0] num_disconnects;

    // register request and acknowledge strobes
    logic        rreq;
    logic [8:0]  raddr;
    logic [31:0] rdata;
    logic        rack;
    logic        wreq;
    logic [8:0]  waddr;
    logic [31:0] wdata;
    logic        wack;

    ssb_tracker ssb_tracker_inst (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .ssb_strobe_i          (ssb_strobe_i),
        .ibar_i                (ibar_i),
        .fs_state_o            (fs_state),
        .sample_cnt_mismatch_o (sample_cnt_mismatch),
        .missed_ssbs_o         (missed_ssbs),
        .ibar_ssb_o            (ibar_ssb),
        .clks_btwn_ssbs_o      (clks_btwn_ssbs),
        .num_disconnects_o     (num_disconnects)
    );

    frame_sync_regmap #(
        .ID (ID)
    ) frame_sync_regmap_inst (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .fs_state_i            (fs_state),
        .sample_cnt_mismatch_i (sample_cnt_mismatch),
        .missed_ssbs_i         (missed_ssbs),
        .ibar_ssb_i            (ibar_ssb),
        .clks_btwn_ssbs_i      (clks_btwn_ssbs),
        .num_disconnects_i     (num_disconnects),
        .rreq_i                (rreq),
        .raddr_i               (raddr),
        .wreq_i                (wreq),
        .waddr_i               (waddr),
        .wdata_i               (wdata),
        .rdata_o               (rdata),
        .rack_o                (rack),
        .wack_o                (wack)
    );

    axi_lite_slave axi_lite_slave_inst (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .wreq_o          (wreq),
        .waddr_o         (waddr),
        .wdata_o         (wdata),
        .wack_i          (wack),
        .rreq_o          (rreq),
        .raddr_o         (raddr),
        .rdata_i         (rdata),
        .rack_i          (rack)
    );

endmodule

/* sim/frame_sync_tb.sv */
`timescale 1ns/1ps
`include "frame_sync_defines.svh"

module frame_sync_tb
    import frame_sync_pkg::*;
();

    localparam logic [31:0] DUT_ID     = 32'h5;
    localparam int          WAIT_LIMIT = 40;

    logic                      clk;
    logic                      reset_n;
    logic                      ssb_strobe;
    logic [2:0]                ibar;
    logic [`FS_ADDR_WIDTH-1:0] s_axi_awaddr;
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    logic [31:0]               s_axi_wdata;
    logic [3:0]                s_axi_wstrb;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    logic [1:0]                s_axi_bresp;
    logic                      s_axi_bvalid;
    logic                      s_axi_bready;
    logic [`FS_ADDR_WIDTH-1:0] s_axi_araddr;
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    logic [31:0]               s_axi_rdata;
    logic [1:0]                s_axi_rresp;
    logic                      s_axi_rvalid;
    logic                      s_axi_rready;

    logic [31:0] lfsr      = 32'h1ddc;
    int          cycle     = 0;
    int          errors    = 0;
    int          checks    = 0;
    bit          timed_out = 1'b0;

    // tracker model, stepped on every clock
    fs_state_t   m_state;
    int          m_age;
    int          m_miss_run;
    int          m_mismatch;
    logic [15:0] m_missed;
    logic [2:0]  m_ibar;
    logic [31:0] m_period;
    logic [31:0] m_disc;

    // model values as the register map saw them at the read request
    fs_state_t   s_state;
    int          s_mismatch;
    logic [15:0] s_missed;
    logic [2:0]  s_ibar;
    logic [31:0] s_period;
    logic [31:0] s_disc;

    frame_sync_top #(
        .ID (DUT_ID)
    ) frame_sync_top_inst (
        .clk_i           (clk),
        .reset_ni        (reset_n),
        .ssb_strobe_i    (ssb_strobe),
        .ibar_i          (ibar),
        .s_axi_awaddr_i  (s_axi_awaddr),
        .s_axi_awvalid_i (s_axi_awvalid),
        .s_axi_awready_o (s_axi_awready),
        .s_axi_wdata_i   (s_axi_wdata),
        .s_axi_wstrb_i   (s_axi_wstrb),
        .s_axi_wvalid_i  (s_axi_wvalid),
        .s_axi_wready_o  (s_axi_wready),
        .s_axi_bresp_o   (s_axi_bresp),
        .s_axi_bvalid_o  (s_axi_bvalid),
        .s_axi_bready_i  (s_axi_bready),
        .s_axi_araddr_i  (s_axi_araddr),
        .s_axi_arvalid_i (s_axi_arvalid),
        .s_axi_arready_o (s_axi_arready),
        .s_axi_rdata_o   (s_axi_rdata),
        .s_axi_rresp_o   (s_axi_rresp),
        .s_axi_rvalid_o  (s_axi_rvalid),
        .s_axi_rready_i  (s_axi_rready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int clip_signed8(int v);
        if (v > 127) begin
            return 127;
        end else if (v < -128) begin
            return -128;
        end
        return v;
    endfunction

    always @(posedge clk) begin : tracker_model
        int   gap;
        logic take;
        // edges since the last accepted ssb
        gap  = m_age + 1;
        take = ssb_strobe && ((m_state != FS_SYNCED) ||
               (gap >= `FS_SSB_PERIOD - `FS_SSB_WINDOW && gap <= `FS_SSB_PERIOD + `FS_SSB_WINDOW));
        if (!reset_n) begin
            m_state    <= FS_SEARCH;
            m_age      <= 0;
            m_miss_run <= 0;
            m_mismatch <= 0;
            m_missed   <= '0;
            m_ibar     <= '0;
            m_period   <= '0;
            m_disc     <= '0;
        end else begin
            m_age <= take ? 0 : gap;
            if (take) begin
                m_ibar <= ibar;
            end
            case (m_state)
                FS_SEARCH: begin
                    if (take) begin
                        m_state <= FS_DETECTED;
                    end
                end
                FS_DETECTED: begin
                    if (take) begin
                        m_state  <= FS_SYNCED;
                        m_period <= 32'(gap);
                    end
                end
                FS_SYNCED: begin
                    if (take) begin
                        m_period   <= 32'(gap);
                        m_mismatch <= clip_signed8(gap - `FS_SSB_PERIOD);
                        m_miss_run <= 0;
                    end else if (gap >= `FS_SSB_PERIOD + `FS_SSB_WINDOW) begin
                        m_missed <= m_missed + 16'd1;
                        // the next ssb is still expected on the nominal grid
                        m_age    <= `FS_SSB_WINDOW;
                        if (m_miss_run + 1 == `FS_MAX_MISSED) begin
                            m_state    <= FS_SEARCH;
                            m_disc     <= m_disc + 32'd1;
                            m_miss_run <= 0;
                        end else begin
                            m_miss_run <= m_miss_run + 1;
                        end
                    end
                end
            endcase
        end
    end

    function automatic void capture_model();
        s_state    = m_state;
        s_mismatch = m_mismatch;
        s_missed   = m_missed;
        s_ibar     = m_ibar;
        s_period   = m_period;
        s_disc     = m_disc;
    endfunction

    function automatic logic [31:0] model_value(logic [8:0] idx);
        case (idx)
            `FS_REG_VERSION:     return 32'h00010061;
            `FS_REG_ID:          return DUT_ID;
            `FS_REG_MAGIC:       return "FS~~";
            `FS_REG_PATTERN:     return 32'h69696969;
            `FS_REG_STATE:       return {30'd0, s_state};
            `FS_REG_MISMATCH:    return 32'(s_mismatch);
            `FS_REG_MISSED:      return {16'd0, s_missed};
            `FS_REG_IBAR:        return {29'd0, s_ibar};
            `FS_REG_PERIOD:      return s_period;
            `FS_REG_DISCONNECTS: return s_disc;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic string reg_name(logic [8:0] idx);
        case (idx)
            `FS_REG_VERSION:     return "version";
            `FS_REG_ID:          return "id";
            `FS_REG_MAGIC:       return "magic";
            `FS_REG_PATTERN:     return "pattern";
            `FS_REG_STATE:       return "state";
            `FS_REG_MISMATCH:    return "mismatch";
            `FS_REG_MISSED:      return "missed";
            `FS_REG_IBAR:        return "ibar";
            `FS_REG_PERIOD:      return "period";
            `FS_REG_DISCONNECTS: return "disconnects";
            default:             return $sformatf("unmapped[%0d]", idx);
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic read_reg(input logic [8:0] idx, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        int delay;
        data          = '0;
        resp          = '0;
        s_axi_araddr  <= {idx, 2'b00};
        s_axi_arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!s_axi_arready && waited < WAIT_LIMIT);
        if (!s_axi_arready) begin
            report_timeout("arready");
            return;
        end
        s_axi_arvalid <= 1'b0;
        // the map samples the status during the request cycle after the handshake
        @(posedge clk);
        capture_model();
        waited = 0;
        while (!s_axi_rvalid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!s_axi_rvalid) begin
            report_timeout("rvalid");
            return;
        end
        delay = int'(random_bits(2));
        repeat (delay) @(posedge clk);
        s_axi_rready <= 1'b1;
        @(posedge clk);
        if (!s_axi_rvalid) begin
            errors++;
            $display("rvalid dropped before rready at %0t ns", $time);
        end
        data         = s_axi_rdata;
        resp         = s_axi_rresp;
        s_axi_rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [8:0] idx, input logic [31:0] data,
                             input logic [3:0] strb);
        int waited;
        int delay;
        s_axi_awaddr  <= {idx, 2'b00};
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!s_axi_awready && waited < WAIT_LIMIT);
        if (!s_axi_awready) begin
            report_timeout("awready");
            return;
        end
        if (!s_axi_wready) begin
            errors++;
            $display("wready did not pulse together with awready at %0t ns", $time);
        end
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        waited = 0;
        while (!s_axi_bvalid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!s_axi_bvalid) begin
            report_timeout("bvalid");
            return;
        end
        delay = int'(random_bits(2));
        repeat (delay) @(posedge clk);
        s_axi_bready <= 1'b1;
        @(posedge clk);
        if (!s_axi_bvalid) begin
            errors++;
            $display("bvalid dropped before bready at %0t ns", $time);
        end
        check_value("bresp", 32'd0, 32'(s_axi_bresp));
        s_axi_bready <= 1'b0;
    endtask

    task automatic check_reg(input logic [8:0] idx);
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(idx, data, resp);
        if (timed_out) return;
        check_value(reg_name(idx), model_value(idx), data);
        check_value({reg_name(idx), " rresp"}, 32'd0, 32'(resp));
    endtask

    task automatic check_status();
        logic [8:0] status_regs [6] = '{`FS_REG_STATE, `FS_REG_MISMATCH, `FS_REG_MISSED,
                                        `FS_REG_IBAR, `FS_REG_PERIOD, `FS_REG_DISCONNECTS};
        foreach (status_regs[i]) begin
            check_reg(status_regs[i]);
            if (timed_out) return;
        end
    endtask

    // one-cycle strobe driven on the edge whose cycle number is target
    task automatic ssb_at(input int target);
        int waited;
        if (cycle > target) begin
            errors++;
            $display("strobe for cycle %0d could not be sent before cycle %0d", target, cycle);
        end
        waited = 0;
        while (cycle < target && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        if (cycle < target) begin
            report_timeout("the SSB slot");
            return;
        end
        ssb_strobe <= 1'b1;
        ibar       <= 3'(random_bits(3));
        @(posedge clk);
        ssb_strobe <= 1'b0;
    endtask

    task automatic run_tests();
        logic [8:0]  id_regs [10] = '{`FS_REG_VERSION, `FS_REG_ID, `FS_REG_MAGIC,
                                      `FS_REG_PATTERN, 9'd2, 9'd6, 9'd7, 9'd8, 9'd14, 9'd511};
        int          anchor;
        int          next;
        int          offset;
        logic [1:0]  kind;
        logic [8:0]  idx;
        foreach (id_regs[i]) begin
            check_reg(id_regs[i]);
            if (timed_out) return;
        end
        // search after reset
        check_status();
        if (timed_out) return;
        anchor = cycle + 4;
        ssb_at(anchor);
        check_status();
        if (timed_out) return;
        for (int n = 0; n < 48; n++) begin
            kind   = 2'(random_bits(2));
            offset = int'(random_bits(4) % 13) - 6;
            next   = anchor + `FS_SSB_PERIOD + offset;
            if (kind == 2'd2) begin
                // stray strobe well before the window
                ssb_at(anchor + 100 + int'(random_bits(6)));
            end else if (kind == 2'd3) begin
                // one to three ssbs dropped
                next = next + (1 + int'(random_bits(2) % 3)) * `FS_SSB_PERIOD;
            end
            if (timed_out) return;
            ssb_at(next);
            if (timed_out) return;
            anchor = next;
            check_status();
            if (timed_out) return;
        end
        // writes change nothing in the map
        for (int n = 0; n < 16; n++) begin
            idx = 9'(random_bits(9));
            write_reg(idx, random_bits(32), 4'(random_bits(4)));
            if (timed_out) return;
            check_reg(idx);
            if (timed_out) return;
        end
        check_status();
    endtask

    initial begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        ssb_strobe    = 1'b0;
        ibar          = '0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        run_tests();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/frame_sync_pkg.sv
rtl/ssb_tracker.sv
rtl/frame_sync_regmap.sv
rtl/axi_lite_slave.sv
rtl/frame_sync_top.sv
sim/frame_sync_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = frame_sync_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

SOURCES = $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS = rtl/frame_sync_defines.svh
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; printf '%s\n' "$$out"; printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
